// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - verilog/mem_bus_pkg.sv
      - verilog/arb_cfg_pkg.sv
      - verilog/channel_arb.sv
      - verilog/line_store.sv
      - verilog/arb_regs.sv
      - verilog/mem_subsys_top.sv
  - target: test
    files:
      - tests/mem_subsys_chk.sv
      - tests/mem_subsys_tb.sv

// ==== project.f ====
verilog/mem_bus_pkg.sv
verilog/arb_cfg_pkg.sv
verilog/channel_arb.sv
verilog/line_store.sv
verilog/arb_regs.sv
verilog/mem_subsys_top.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

// ==== tests/mem_subsys_chk.sv ====
`timescale 1ns/1ps

module mem_subsys_chk (
    input logic clock,
    input logic reset_n,
    input logic mem_chip_enable,
    input logic mem_done,
    input logic icache_grant,
    input logic dcache_grant,
    input logic icache_done,
    input logic dcache_done
);

    int assert_fails = 0;   // Failure count that the testbench reads

    // Chip enable is a one-cycle pulse
    ce_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        mem_chip_enable |=> !mem_chip_enable)
        else begin
            assert_fails++;
            $error("chip enable high two cycles in a row");
        end

    grant_excl: assert property (@(posedge clock) disable iff (!reset_n)
        !(icache_grant && dcache_grant))
        else begin
            assert_fails++;
            $error("both grants high together");
        end

    done_excl: assert property (@(posedge clock) disable iff (!reset_n)
        !(icache_done && dcache_done))
        else begin
            assert_fails++;
            $error("both dones high together");
        end

    // A channel done only alongside the memory done
    done_match: assert property (@(posedge clock) disable iff (!reset_n)
        mem_done == (icache_done || dcache_done))
        else begin
            assert_fails++;
            $error("channel done does not coincide with mem_done");
        end

endmodule

bind channel_arb mem_subsys_chk chk_i (.*);

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb
    import mem_bus_pkg::*;
    import arb_cfg_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int N_SINGLE        = 24;   // Transactions per channel
    localparam int N_PAIRS         = 6;    // Simultaneous pairs per policy
    localparam int N_TXN           = 2 * N_SINGLE + 4 * N_PAIRS;
    localparam int WATCHDOG_CYCLES = N_TXN * (LINE_LATENCY + 4) + 200;

    logic        clock;
    logic        reset_n;
    logic        icache_valid, icache_ready, icache_done;
    logic        dcache_valid, dcache_ready, dcache_done;
    index_t      icache_index, dcache_index;
    line_t       icache_read_data, dcache_read_data, dcache_write_data;
    dbus_op_t    dcache_op;
    logic        psel, penable, pwrite, pready, pslverr;
    apb_addr_t   paddr;
    apb_data_t   pwdata, prdata;

    // Reference model
    line_t       model_lines [LINE_COUNT];
    apb_data_t   model_icount, model_dcount;
    logic        last_dcache;   // Winner of the last tie

    string       test_name;
    int          errors, checks, tests, failed_tests, test_mark;

    mem_subsys_top dut_i (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("TIMEOUT: run timed out waiting for done after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_line(string what, line_t exp, line_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(string what, apb_data_t exp, apb_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    function automatic line_t random_line();
        line_t l;
        for (int w = 0; w < LINE_BITS / 32; w++)
            l[w*32 +: 32] = $urandom;
        return l;
    endfunction

    task automatic finish_test();
        tests++;
        if (errors == test_mark) begin
            $display("test %-14s ok", test_name);
        end else begin
            failed_tests++;
            $display("test %-14s %0d errors", test_name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    // Zero-wait APB transfer with the response sampled mid access phase
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        #1;
        check_bit("pready", 1'b1, pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Raise valid on one or both channels, hold until done, drop the cycle after
    task automatic run_requests(input logic do_i, input logic do_d, input index_t iidx,
                                input index_t didx, input dbus_op_t op, input line_t wdata,
                                output int i_cycles, output int d_cycles);
        int   cycles;
        logic i_wait;
        logic d_wait;
        logic i_rdy;
        logic d_rdy;
        cycles   = 0;
        i_cycles = 0;
        d_cycles = 0;
        i_wait   = do_i;
        d_wait   = do_d;
        i_rdy    = 1'b0;
        d_rdy    = 1'b0;
        @(negedge clock);
        icache_valid      = do_i;
        icache_index      = iidx;
        dcache_valid      = do_d;
        dcache_index      = didx;
        dcache_op         = op;
        dcache_write_data = wdata;
        while (i_wait || d_wait) begin
            @(negedge clock);
            cycles++;
            if (!i_wait) icache_valid = 1'b0;
            if (!d_wait) dcache_valid = 1'b0;
            i_rdy = i_rdy | icache_ready;   // Ready shows only for a granted channel
            d_rdy = d_rdy | dcache_ready;
            if (i_wait && icache_done) begin
                i_wait   = 1'b0;
                i_cycles = cycles;
            end
            if (d_wait && dcache_done) begin
                d_wait   = 1'b0;
                d_cycles = cycles;
            end
        end
        @(negedge clock);
        icache_valid = 1'b0;
        dcache_valid = 1'b0;
        check_bit("icache ready", do_i, i_rdy);
        check_bit("dcache ready", do_d, d_rdy);
    endtask

    initial begin
        apb_data_t   rd;
        logic        err;
        index_t      iidx, didx;
        dbus_op_t    op;
        line_t       wdata, exp_i;
        int          i_cyc, d_cyc;
        logic        d_first_exp;
        arb_policy_t pol;

        void'($urandom(84));
        clock        = 1'b0;
        reset_n      = 1'b0;
        icache_valid = 1'b0;
        icache_index = '0;
        dcache_valid = 1'b0;
        dcache_index = '0;
        dcache_op    = DBUS_READ;
        dcache_write_data = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < LINE_COUNT; i++)
            model_lines[i] = '0;
        model_icount = '0;
        model_dcount = '0;
        last_dcache  = 1'b0;
        repeat (3) @(negedge clock);
        reset_n = 1'b1;

        test_name = "reset";
        check_bit("icache_ready", 1'b0, icache_ready);
        check_bit("dcache_ready", 1'b0, dcache_ready);
        check_bit("icache_done", 1'b0, icache_done);
        check_bit("dcache_done", 1'b0, dcache_done);
        check_bit("chip enable", 1'b0, dut_i.mem_chip_enable);
        check_bit("pslverr", 1'b0, pslverr);
        apb_access(1'b0, REG_CTRL, '0, rd, err);
        check_reg("ctrl", '0, rd);
        apb_access(1'b0, REG_ICOUNT, '0, rd, err);
        check_reg("icount", '0, rd);
        apb_access(1'b0, REG_DCOUNT, '0, rd, err);
        check_reg("dcount", '0, rd);
        finish_test();

        test_name = "dcache";
        for (int n = 0; n < N_SINGLE; n++) begin
            didx  = {$urandom, $urandom};
            op    = dbus_op_t'($urandom_range(1, 0));
            wdata = random_line();
            run_requests(1'b0, 1'b1, '0, didx, op, wdata, i_cyc, d_cyc);
            if (op == DBUS_WRITE)
                model_lines[didx[LINE_INDEX_BITS-1:0]] = wdata;
            check_line("read data", model_lines[didx[LINE_INDEX_BITS-1:0]], dcache_read_data);
            check_reg("latency", LINE_LATENCY + 1, d_cyc);
            model_dcount++;
        end
        finish_test();

        test_name = "icache";
        for (int n = 0; n < N_SINGLE; n++) begin
            iidx = {$urandom, $urandom};
            run_requests(1'b1, 1'b0, iidx, '0, DBUS_READ, '0, i_cyc, d_cyc);
            check_line("read data", model_lines[iidx[LINE_INDEX_BITS-1:0]], icache_read_data);
            check_reg("latency", LINE_LATENCY + 1, i_cyc);
            model_icount++;
        end
        finish_test();

        // Both channels at once under dcache first and then round robin
        for (int p = 0; p < 2; p++) begin
            pol       = arb_policy_t'(p);
            test_name = (pol == POLICY_DCACHE_FIRST) ? "dcache_first" : "round_robin";
            apb_access(1'b1, REG_CTRL, apb_data_t'(pol), rd, err);
            for (int n = 0; n < N_PAIRS; n++) begin
                iidx  = {$urandom, $urandom};
                didx  = {$urandom, $urandom};
                op    = dbus_op_t'($urandom_range(1, 0));
                wdata = random_line();
                d_first_exp = (pol == POLICY_DCACHE_FIRST) || !last_dcache;
                run_requests(1'b1, 1'b1, iidx, didx, op, wdata, i_cyc, d_cyc);
                if (!d_first_exp)
                    exp_i = model_lines[iidx[LINE_INDEX_BITS-1:0]];
                if (op == DBUS_WRITE)
                    model_lines[didx[LINE_INDEX_BITS-1:0]] = wdata;
                if (d_first_exp)
                    exp_i = model_lines[iidx[LINE_INDEX_BITS-1:0]];
                check_bit("dcache first", d_first_exp, d_cyc < i_cyc);
                check_line("icache data", exp_i, icache_read_data);
                check_line("dcache data", model_lines[didx[LINE_INDEX_BITS-1:0]],
                           dcache_read_data);
                model_icount++;
                model_dcount++;
                last_dcache = d_first_exp;
            end
            finish_test();
        end

        test_name = "apb_regs";
        apb_access(1'b0, REG_ICOUNT, '0, rd, err);
        check_reg("icount", model_icount, rd);
        apb_access(1'b0, REG_DCOUNT, '0, rd, err);
        check_reg("dcount", model_dcount, rd);
        check_bit("mapped pslverr", 1'b0, err);
        apb_access(1'b1, REG_ICOUNT, '1, rd, err);
        apb_access(1'b1, REG_DCOUNT, '1, rd, err);
        apb_access(1'b0, REG_ICOUNT, '0, rd, err);
        check_reg("icount cleared", '0, rd);
        apb_access(1'b0, REG_DCOUNT, '0, rd, err);
        check_reg("dcount cleared", '0, rd);
        apb_access(1'b0, apb_addr_t'($urandom_range(8'hFF, 8'h10)), '0, rd, err);
        check_bit("unmapped pslverr", 1'b1, err);
        finish_test();

        if (dut_i.arb_i.chk_i.assert_fails != 0) begin
            $display("Bound arbiter assertions failed %0d times",
                     dut_i.arb_i.chk_i.assert_fails);
            errors += dut_i.arb_i.chk_i.assert_fails;
        end
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verilog/arb_cfg_pkg.sv ====
package arb_cfg_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Register map
    localparam apb_addr_t REG_CTRL   = 8'h00;   // Bit 0 selects the policy
    localparam apb_addr_t REG_ICOUNT = 8'h04;   // Icache grant count
    localparam apb_addr_t REG_DCOUNT = 8'h08;   // Dcache grant count

    // Arbitration policy as encoded in REG_CTRL bit 0
    typedef enum logic {
        POLICY_DCACHE_FIRST = 1'b0,
        POLICY_ROUND_ROBIN  = 1'b1
    } arb_policy_t;

endpackage

// ==== verilog/arb_regs.sv ====
`timescale 1ns/1ps

module arb_regs
    import arb_cfg_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // APB slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,

    // Arbiter side
    input  logic        icache_grant,
    input  logic        dcache_grant,
    output arb_policy_t policy
);

    apb_data_t icount;
    apb_data_t dcount;
    logic      access;
    logic      wr_access;
    logic      addr_hit;

    // Saturating count where a clear beats an increment
    function automatic apb_data_t count_next(apb_data_t count, logic clear, logic inc);
        if (clear)
            return '0;
        if (inc && count != '1)
            return count + 1'b1;
        return count;
    endfunction

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign pready    = access;               // No wait states
    assign pslverr   = access & ~addr_hit;

    always_comb begin
        prdata   = '0;
        addr_hit = 1'b1;
        case (paddr)
            REG_CTRL:   prdata = {31'd0, policy};
            REG_ICOUNT: prdata = icount;
            REG_DCOUNT: prdata = dcount;
            default:    addr_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            policy <= POLICY_DCACHE_FIRST;
            icount <= '0;
            dcount <= '0;
        end else begin
            if (wr_access && paddr == REG_CTRL)
                policy <= arb_policy_t'(pwdata[0]);
            icount <= count_next(icount, wr_access && paddr == REG_ICOUNT, icache_grant);
            dcount <= count_next(dcount, wr_access && paddr == REG_DCOUNT, dcache_grant);
        end
    end

endmodule

// ==== verilog/channel_arb.sv ====
`timescale 1ns/1ps

module channel_arb
    import mem_bus_pkg::*;
    import arb_cfg_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,

    // Icache read channel
    input  logic        icache_valid,
    input  index_t      icache_index,
    output logic        icache_ready,
    output line_t       icache_read_data,
    output logic        icache_done,

    // Dcache read/write channel
    input  logic        dcache_valid,
    input  index_t      dcache_index,
    input  line_t       dcache_write_data,
    input  dbus_op_t    dcache_op,
    output logic        dcache_ready,
    output line_t       dcache_read_data,
    output logic        dcache_done,

    // Memory port
    output logic        mem_chip_enable,
    output index_t      mem_index,
    output logic        mem_write_enable,
    output line_t       mem_write_data,
    input  line_t       mem_read_data,
    input  logic        mem_done,
    input  logic        mem_ready,

    // Register block
    input  arb_policy_t policy,
    output logic        icache_grant,
    output logic        dcache_grant
);

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DCACHE = 2'b01,
        ICACHE = 2'b10
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;
    logic       pick_dcache;
    logic       last_dcache;     // Last tie went to the dcache
    logic       grant_level;
    logic       grant_level_q;

    // Dcache wins a tie unless round robin says the icache is owed a turn
    assign pick_dcache = dcache_valid &&
                         (!icache_valid || policy == POLICY_DCACHE_FIRST || !last_dcache);

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (mem_ready) begin
                    if (pick_dcache)
                        state_next = DCACHE;
                    else if (icache_valid)
                        state_next = ICACHE;
                end
            end
            DCACHE, ICACHE: begin
                if (mem_done)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= IDLE;
            grant_level_q <= 1'b0;
            last_dcache   <= 1'b0;
        end else begin
            state         <= state_next;
            grant_level_q <= grant_level;   // Delayed grant level for the pulse
            if (state == IDLE && mem_ready && icache_valid && dcache_valid)
                last_dcache <= pick_dcache;   // Winner of this tie
        end
    end

    // Chip enable only in the first grant cycle
    assign grant_level     = (state != IDLE);
    assign mem_chip_enable = grant_level & ~grant_level_q;
    assign icache_grant    = mem_chip_enable & (state == ICACHE);
    assign dcache_grant    = mem_chip_enable & (state == DCACHE);

    // Granted channel onto the memory port
    assign mem_index        = (state == ICACHE) ? icache_index : dcache_index;
    assign mem_write_enable = (state == DCACHE) && (dcache_op == DBUS_WRITE);
    assign mem_write_data   = dcache_write_data;

    assign icache_ready = (state == ICACHE) & mem_ready;
    assign dcache_ready = (state == DCACHE) & mem_ready;
    assign icache_done  = (state == ICACHE) & mem_done;
    assign dcache_done  = (state == DCACHE) & mem_done;

    // Read data held per channel until its next completion
    always_ff @(posedge clock) begin
        if (icache_done)
            icache_read_data <= mem_read_data;
        if (dcache_done)
            dcache_read_data <= mem_read_data;
    end

endmodule

// ==== verilog/line_store.sv ====
`timescale 1ns/1ps

module line_store
    import mem_bus_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   mem_chip_enable,
    input  index_t mem_index,
    input  logic   mem_write_enable,
    input  line_t  mem_write_data,
    output line_t  mem_read_data,
    output logic   mem_done,
    output logic   mem_ready
);

    line_t                      lines [LINE_COUNT];
    logic [LINE_INDEX_BITS-1:0] req_addr;
    logic                       req_write;
    line_t                      req_data;
    logic [LINE_LAT_BITS-1:0]   count;     // Cycles left before done
    logic                       accept;
    logic                       finish;

    assign accept = mem_chip_enable & mem_ready;
    assign finish = (count == LINE_LAT_BITS'(1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_ready <= 1'b1;
            mem_done  <= 1'b0;
            count     <= '0;
        end else begin
            mem_done <= 1'b0;
            if (accept) begin
                mem_ready <= 1'b0;
                count     <= LINE_LAT_BITS'(LINE_LATENCY - 1);
            end else if (count != '0) begin
                count <= count - 1'b1;
                if (finish)
                    mem_done <= 1'b1;
            end else if (mem_done) begin
                mem_ready <= 1'b1;            // Ready again the cycle after done
            end
        end
    end

    // Request captured at the chip enable
    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr  <= mem_index[LINE_INDEX_BITS-1:0];
            req_write <= mem_write_enable;
            req_data  <= mem_write_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < LINE_COUNT; i++)
                lines[i] <= '0;
        end else if (finish && req_write) begin
            lines[req_addr] <= req_data;
        end
    end

    // A write echoes the new line
    always_ff @(posedge clock) begin
        if (finish)
            mem_read_data <= req_write ? req_data : lines[req_addr];
    end

endmodule

// ==== verilog/mem_bus_pkg.sv ====
package mem_bus_pkg;

    // Store geometry
    localparam int LINE_INDEX_BITS = 4;
    localparam int LINE_COUNT      = 16;
    localparam int LINE_BITS       = 512;
    localparam int INDEX_BITS      = 64;

    // Cycles from an accepted chip enable to done
    localparam int LINE_LATENCY  = 4;
    localparam int LINE_LAT_BITS = $clog2(LINE_LATENCY + 1);

    // One memory line
    typedef logic [LINE_BITS-1:0] line_t;

    // Full line index; only the low LINE_INDEX_BITS reach the store
    typedef logic [INDEX_BITS-1:0] index_t;

    // Data cache operation
    typedef enum logic {
        DBUS_READ  = 1'b0,
        DBUS_WRITE = 1'b1
    } dbus_op_t;

endpackage

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top
    import mem_bus_pkg::*;
    import arb_cfg_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,

    input  logic      icache_valid,
    input  index_t    icache_index,
    output logic      icache_ready,
    output line_t     icache_read_data,
    output logic      icache_done,

    input  logic      dcache_valid,
    input  index_t    dcache_index,
    input  line_t     dcache_write_data,
    input  dbus_op_t  dcache_op,
    output logic      dcache_ready,
    output line_t     dcache_read_data,
    output logic      dcache_done,

    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr
);

    // Memory port
    logic        mem_chip_enable;
    index_t      mem_index;
    logic        mem_write_enable;
    line_t       mem_write_data;
    line_t       mem_read_data;
    logic        mem_done;
    logic        mem_ready;

    // Statistics and configuration
    logic        icache_grant;
    logic        dcache_grant;
    arb_policy_t policy;

    channel_arb arb_i (.*);
    line_store  store_i (.*);
    arb_regs    regs_i (.*);

endmodule
